//--- bench/fec_erasure_path_tb.sv
`timescale 1ns/100ps
`include "fec_config.svh"
`default_nettype none

module fec_erasure_path_tb;
    import fec_pkg::*;

    localparam int NUM_SYM = `FEC_NUM_CW*`FEC_RS_K;
    localparam int DW      = NUM_SYM*`FEC_SYM_SIZE;
    localparam int LATENCY = 6;                // Ready-high cycles from input to output

    logic               clk;
    logic               rst_n;
    logic               in_valid;
    sym_t [NUM_SYM-1:0] in_data;
    err_loc_t           in_err_loc;
    logic               in_ready;
    logic               out_valid;
    sym_t [NUM_SYM-1:0] out_data;
    logic               out_ready;

    // One stimulus item per table row
    string         row_name [$];
    err_loc_t      row_loc  [$];
    logic [7:0]    row_mask [$];           // out_ready per cycle starting at bit 0
    bit            row_rand [$];
    logic [DW-1:0] row_data [$];

    // Items in flight
    logic [DW-1:0] exp_data_q [$];
    string         exp_name_q [$];
    int            exp_tick_q [$];

    logic [31:0]   rand_state   = 32'hb9e0_b0f7;
    int            ready_ticks  = 0;
    bit            table_loaded = 1'b0;
    bit            hold_pending = 1'b0;
    logic          prev_valid   = 1'b0;
    logic [DW-1:0] prev_data    = '0;

    fec_erasure_path dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_err_loc (in_err_loc),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_ready  (out_ready)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    task automatic check_equal(input string name, input logic [DW-1:0] expected,
                               input logic [DW-1:0] actual);
        if (actual !== expected) begin
            $display("ERR %s: expected %h, actual %h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic add_row(input string name, input err_loc_t loc, input logic [7:0] mask,
                           input bit rnd, input logic [DW-1:0] data);
        row_name.push_back(name);
        row_loc.push_back(loc);
        row_mask.push_back(mask);
        row_rand.push_back(rnd);
        row_data.push_back(data);
    endtask

    // ########################################################################
    // Test table
    // ########################################################################
    task automatic load_table();
        add_row("two_d0_d1",  4'd0,  8'hff, 1'b0, 32'h0123_4567);
        add_row("two_d0_d2",  4'd1,  8'hff, 1'b0, 32'h89ab_cdef);
        add_row("two_d0_d3",  4'd2,  8'hff, 1'b0, 32'hfedc_ba98);
        add_row("one_d0_p0",  4'd3,  8'hff, 1'b0, 32'h7654_3210);  // Rebuilt from P1
        add_row("one_d0_p1",  4'd4,  8'hff, 1'b0, 32'hf0f0_0f0f);
        add_row("two_d1_d2",  4'd5,  8'hff, 1'b0, 32'h0000_0000);
        add_row("two_d1_d3",  4'd6,  8'hff, 1'b0, 32'hffff_ffff);
        add_row("one_d1_p0",  4'd7,  8'hff, 1'b0, 32'h5a5a_a5a5);
        add_row("one_d1_p1",  4'd8,  8'hff, 1'b0, 32'h1357_9bdf);
        add_row("two_d2_d3",  4'd9,  8'hff, 1'b0, 32'h2468_ace0);
        add_row("one_d2_p0",  4'd10, 8'hff, 1'b0, 32'h8000_0001);
        add_row("one_d2_p1",  4'd11, 8'hff, 1'b0, 32'h1111_2222);
        add_row("one_d3_p0",  4'd12, 8'hff, 1'b0, 32'hc3c3_3c3c);
        add_row("one_d3_p1",  4'd13, 8'hff, 1'b0, 32'h9e37_79b9);
        add_row("none_p0_p1", 4'd14, 8'hff, 1'b0, 32'hdead_beef);
        add_row("stall_a",    4'd3,  8'b1011_0010, 1'b1, '0);
        add_row("stall_b",    4'd9,  8'b0101_0100, 1'b1, '0);
        add_row("stall_c",    4'd14, 8'b1000_0000, 1'b1, '0);
        add_row("stall_d",    4'd7,  8'b0110_0110, 1'b1, '0);
        add_row("rand_0",     4'd11, 8'hff, 1'b1, '0);     // Back to back from here
        add_row("rand_1",     4'd0,  8'hff, 1'b1, '0);
        add_row("rand_2",     4'd5,  8'hff, 1'b1, '0);
        add_row("rand_3",     4'd12, 8'hff, 1'b1, '0);
        add_row("rand_4",     4'd2,  8'hff, 1'b1, '0);
        add_row("rand_5",     4'd8,  8'hff, 1'b1, '0);
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                // 100 ns period
    end

    // Driver
    initial begin
        logic [DW-1:0] data;
        int            bit_idx;
        bit            accepted;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_data    = '0;
        in_err_loc = '0;
        out_ready  = 1'b0;
        load_table();
        table_loaded = 1'b1;
        repeat (4) @(posedge clk);
        rst_n     <= 1'b1;
        out_ready <= 1'b1;
        repeat (3) @(posedge clk);
        check_equal("idle_out_valid", '0, DW'(out_valid));

        for (int r = 0; r < row_name.size(); r++) begin
            if (row_rand[r]) begin
                rand_state = xorshift32(rand_state);
                data       = rand_state;
            end else begin
                data = row_data[r];
            end
            bit_idx  = 0;
            accepted = 1'b0;
            in_valid   <= 1'b1;
            in_data    <= data;
            in_err_loc <= row_loc[r];
            out_ready  <= row_mask[r][0];
            while (!accepted) begin
                @(posedge clk);
                if (in_valid && in_ready) begin
                    accepted = 1'b1;
                    exp_data_q.push_back(data);
                    exp_name_q.push_back(row_name[r]);
                    exp_tick_q.push_back(ready_ticks);
                end else begin
                    bit_idx   = (bit_idx + 1) % 8;
                    out_ready <= row_mask[r][bit_idx];
                end
            end
        end

        in_valid  <= 1'b0;
        out_ready <= 1'b1;
        while (exp_data_q.size() != 0)
            @(posedge clk);
        repeat (2) @(posedge clk);
        $display("TEST PASSED");
        $finish;
    end

    // ########################################################################
    // Monitor samples all values before the edge updates them
    // ########################################################################
    always @(posedge clk) begin
        string         name;
        logic [DW-1:0] expected;
        int            tick;
        if (rst_n) begin
            check_equal("in_ready", DW'(out_ready), DW'(in_ready));
            if (hold_pending) begin                        // Last edge was a stall
                check_equal("hold_valid", DW'(prev_valid), DW'(out_valid));
                if (prev_valid)
                    check_equal("hold_data", prev_data, out_data);
            end
            if (out_valid && out_ready) begin
                if (exp_data_q.size() == 0) begin
                    $display("Output handshake with no item in flight");
                    $display("TEST FAILED");
                    $fatal(1, "unexpected output item");
                end else begin
                    name     = exp_name_q.pop_front();
                    expected = exp_data_q.pop_front();
                    tick     = exp_tick_q.pop_front();
                    check_equal(name, expected, out_data);
                    check_equal({name, "_latency"}, DW'(tick + LATENCY), DW'(ready_ticks));
                end
            end
            if (out_ready)
                ready_ticks <= ready_ticks + 1;
            hold_pending <= !out_ready;
            prev_valid   <= out_valid;
            prev_data    <= out_data;
        end
    end

    // Watchdog sized from the table
    initial begin
        int limit;
        wait (table_loaded);
        limit = row_name.size() * 8 + 50;
        repeat (limit) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", limit);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

//--- rtl/fec_config.svh
`ifndef FEC_CONFIG_SVH
`define FEC_CONFIG_SVH

`default_nettype none

`define FEC_SYM_SIZE 4     // Bits per GF(16) symbol
`define FEC_RS_K     4     // Data symbols per codeword
`define FEC_RS_2T    2     // Parity symbols per codeword
`define FEC_RS_N     6     // Codeword length
`define FEC_NUM_CW   2     // Codewords per data unit
`define FEC_NUM_H    15    // Two-of-six erasure patterns

`default_nettype wire

`endif

//--- rtl/fec_encoder.sv
`timescale 1ns/100ps
`include "fec_config.svh"
`default_nettype none

module fec_encoder (
    input  wire                                            clk,
    input  wire                                            rst_n,
    input  wire                                            in_valid,
    input  wire fec_pkg::sym_t [`FEC_NUM_CW*`FEC_RS_K-1:0] in_data,
    input  wire fec_pkg::err_loc_t                         in_err_loc,
    input  wire                                            ready,
    output logic                                           out_valid,
    output fec_pkg::sym_t [`FEC_NUM_CW*`FEC_RS_K-1:0]      out_data,
    output fec_pkg::sym_t [`FEC_NUM_CW*`FEC_RS_2T-1:0]     out_parity,
    output fec_pkg::err_loc_t                              out_err_loc
);
    import fec_pkg::*;

    sym_t [`FEC_NUM_CW*`FEC_RS_2T-1:0] parity;

    // P0 = sum of data, P1 = sum of alpha^j * d_j
    always_comb begin
        sym_t p0;
        sym_t p1;
        for (int i = 0; i < `FEC_NUM_CW; i++) begin
            p0 = '0;
            p1 = '0;
            for (int j = 0; j < `FEC_RS_K; j++) begin
                p0 ^= in_data[i*`FEC_RS_K + j];
                p1 ^= gf_mul(gf_alpha_pow(pos_idx_t'(j)), in_data[i*`FEC_RS_K + j]);
            end
            parity[i*`FEC_RS_2T]     = p0;
            parity[i*`FEC_RS_2T + 1] = p1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            out_valid <= 1'b0;
        else if (ready)
            out_valid <= in_valid;    // Bubbles travel too
    end

    always_ff @(posedge clk) begin
        if (ready) begin
            out_data    <= in_data;
            out_parity  <= parity;
            out_err_loc <= in_err_loc;  // Pattern index rides along
        end
    end

    a_valid_known: assert property (
        @(posedge clk) disable iff (!rst_n) !$isunknown(out_valid)
    ) else $error("fec_encoder: out_valid unknown after reset");

endmodule

`default_nettype wire

//--- rtl/fec_erasure_decoder.sv
`timescale 1ns/100ps
`include "fec_config.svh"
`default_nettype none

module fec_erasure_decoder (
    input  wire                                            clk,
    input  wire                                            rst_n,
    input  wire fec_pkg::sym_t [`FEC_NUM_CW*`FEC_RS_K-1:0] surv_data,
    input  wire fec_pkg::err_loc_t                         err_loc,
    input  wire                                            in_valid,
    input  wire                                            ready,
    output logic                                           out_valid,
    output fec_pkg::sym_t [`FEC_NUM_CW*`FEC_RS_K-1:0]      out_data
);
    import fec_pkg::*;

    typedef enum logic [1:0] {
        NONE_DATA,   // Only parity lost
        ONE_DATA,    // One data and one parity lost
        TWO_DATA     // Both parity survived
    } erasure_case_e;

    logic [`FEC_RS_N-1:0]              evec;
    pos_idx_t                          pos_a;
    pos_idx_t                          pos_b;
    erasure_case_e                     case_c;
    sym_t [`FEC_NUM_CW*`FEC_RS_K-1:0]  data_c;
    sym_t [`FEC_NUM_CW-1:0]            s0_c;
    sym_t [`FEC_NUM_CW-1:0]            s1_c;

    pos_idx_t                          a_s1;
    pos_idx_t                          b_s1;
    erasure_case_e                     case_s1;
    sym_t [`FEC_NUM_CW*`FEC_RS_K-1:0]  data_s1;
    sym_t [`FEC_NUM_CW-1:0]            s0_s1;
    sym_t [`FEC_NUM_CW-1:0]            s1_s1;
    logic                              valid_s1;

    sym_t                              denom;
    sym_t [`FEC_NUM_CW*`FEC_RS_K-1:0]  result;

    // ########################################################################
    // Stage 1 re-expands survivors, locates erasures and forms syndromes
    // ########################################################################
    always_comb begin
        logic                 found;
        pos_idx_t             slot;
        sym_t [`FEC_RS_N-1:0] full;
        evec  = RS_ERR_LOC_LUT[err_loc];
        pos_a = '0;
        pos_b = '0;
        found = 1'b0;
        for (int p = 0; p < `FEC_RS_N; p++) begin
            if (evec[p]) begin
                if (!found)
                    pos_a = pos_idx_t'(p);   // Lower erased position
                else
                    pos_b = pos_idx_t'(p);
                found = 1'b1;
            end
        end

        if (pos_a >= pos_idx_t'(`FEC_RS_K))
            case_c = NONE_DATA;
        else if (pos_b >= pos_idx_t'(`FEC_RS_K))
            case_c = ONE_DATA;
        else
            case_c = TWO_DATA;

        for (int i = 0; i < `FEC_NUM_CW; i++) begin
            slot = '0;
            for (int p = 0; p < `FEC_RS_N; p++) begin
                if (evec[p]) begin
                    full[p] = '0;             // Erased symbols add nothing
                end else begin
                    full[p] = surv_data[i*`FEC_RS_K + int'(slot)];
                    slot    = slot + 3'd1;
                end
            end
            s0_c[i] = full[`FEC_RS_K];
            s1_c[i] = full[`FEC_RS_K + 1];
            for (int j = 0; j < `FEC_RS_K; j++) begin
                data_c[i*`FEC_RS_K + j] = full[j];
                s0_c[i] ^= full[j];
                s1_c[i] ^= gf_mul(gf_alpha_pow(pos_idx_t'(j)), full[j]);
            end
        end
    end

    // ########################################################################
    // Stage 2 solves for the erased data symbols
    // ########################################################################
    assign denom = gf_alpha_pow(a_s1) ^ gf_alpha_pow(b_s1);

    always_comb begin
        sym_t d_a;
        sym_t inv_a;
        sym_t inv_den;
        inv_a   = gf_inv(gf_alpha_pow(a_s1));
        inv_den = gf_inv(denom);
        result  = data_s1;
        for (int i = 0; i < `FEC_NUM_CW; i++) begin
            case (case_s1)
                ONE_DATA: begin
                    if (b_s1 == pos_idx_t'(`FEC_RS_K))
                        d_a = gf_mul(s1_s1[i], inv_a);  // P0 lost so P1 is used
                    else
                        d_a = s0_s1[i];
                    result[i*`FEC_RS_K + int'(a_s1)] = d_a;
                end
                TWO_DATA: begin
                    d_a = gf_mul(s1_s1[i] ^ gf_mul(gf_alpha_pow(b_s1), s0_s1[i]), inv_den);
                    result[i*`FEC_RS_K + int'(a_s1)] = d_a;
                    result[i*`FEC_RS_K + int'(b_s1)] = s0_s1[i] ^ d_a;
                end
                default: ;                          // Data already complete
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_s1  <= 1'b0;
            out_valid <= 1'b0;
        end else if (ready) begin
            valid_s1  <= in_valid;
            out_valid <= valid_s1;
        end
    end

    always_ff @(posedge clk) begin
        if (ready) begin
            a_s1     <= pos_a;
            b_s1     <= pos_b;
            case_s1  <= case_c;
            data_s1  <= data_c;
            s0_s1    <= s0_c;
            s1_s1    <= s1_c;
            out_data <= result;
        end
    end

    a_two_data_solvable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (valid_s1 && case_s1 == TWO_DATA) |-> (denom != '0)
    ) else $error("fec_erasure_decoder: singular system for %0d,%0d", a_s1, b_s1);

endmodule

`default_nettype wire

//--- rtl/fec_erasure_path.sv
`timescale 1ns/100ps
`include "fec_config.svh"
`default_nettype none

module fec_erasure_path (
    input  wire                                            clk,
    input  wire                                            rst_n,
    input  wire                                            in_valid,
    input  wire fec_pkg::sym_t [`FEC_NUM_CW*`FEC_RS_K-1:0] in_data,
    input  wire fec_pkg::err_loc_t                         in_err_loc,
    output logic                                           in_ready,
    output logic                                           out_valid,
    output fec_pkg::sym_t [`FEC_NUM_CW*`FEC_RS_K-1:0]      out_data,
    input  wire                                            out_ready
);
    import fec_pkg::*;

    logic                              enc_valid;
    sym_t [`FEC_NUM_CW*`FEC_RS_K-1:0]  enc_data;
    sym_t [`FEC_NUM_CW*`FEC_RS_2T-1:0] enc_parity;
    err_loc_t                          enc_err_loc;
    logic                              inj_valid;
    sym_t [`FEC_NUM_CW*`FEC_RS_K-1:0]  inj_data;
    err_loc_t                          inj_err_loc;

    fec_encoder encoder_i (                 // 1 cycle
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_data     (in_data),
        .in_err_loc  (in_err_loc),
        .ready       (out_ready),
        .out_valid   (enc_valid),
        .out_data    (enc_data),
        .out_parity  (enc_parity),
        .out_err_loc (enc_err_loc)
    );

    fec_err_inject inject_i (               // 3 cycles
        .clk            (clk),
        .rst_n          (rst_n),
        .data_in        (enc_data),
        .parity_in      (enc_parity),
        .err_loc_in     (enc_err_loc),
        .data_in_valid  (enc_valid),
        .data_in_ready  (in_ready),
        .data_out       (inj_data),
        .err_loc_out    (inj_err_loc),
        .data_out_valid (inj_valid),
        .data_out_ready (out_ready)
    );

    fec_erasure_decoder decoder_i (         // 2 cycles
        .clk       (clk),
        .rst_n     (rst_n),
        .surv_data (inj_data),
        .err_loc   (inj_err_loc),
        .in_valid  (inj_valid),
        .ready     (out_ready),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

`default_nettype wire

//--- rtl/fec_err_inject.sv
`timescale 1ns/100ps
`include "fec_config.svh"
`default_nettype none

module fec_err_inject (
    input  wire                                             clk,
    input  wire                                             rst_n,
    input  wire fec_pkg::sym_t [`FEC_NUM_CW*`FEC_RS_K-1:0]  data_in,
    input  wire fec_pkg::sym_t [`FEC_NUM_CW*`FEC_RS_2T-1:0] parity_in,
    input  wire fec_pkg::err_loc_t                          err_loc_in,
    input  wire                                             data_in_valid,
    output logic                                            data_in_ready,
    output fec_pkg::sym_t [`FEC_NUM_CW*`FEC_RS_K-1:0]       data_out,
    output fec_pkg::err_loc_t                               err_loc_out,
    output logic                                            data_out_valid,
    input  wire                                             data_out_ready
);
    import fec_pkg::*;

    sym_t [`FEC_NUM_CW-1:0][`FEC_RS_N-1:0] cw_in;
    sym_t [`FEC_NUM_CW-1:0][`FEC_RS_N-1:0] cw_s1;
    sym_t [`FEC_NUM_CW-1:0][`FEC_RS_N-1:0] cw_s2;
    logic [`FEC_RS_N-1:0]                  erase_s1;
    logic [`FEC_RS_N-1:0]                  erase_s2;
    pos_idx_t [`FEC_RS_N-1:0]              out_idx_c;
    pos_idx_t [`FEC_RS_N-1:0]              out_idx_s2;
    err_loc_t                              err_loc_s1;
    err_loc_t                              err_loc_s2;
    logic                                  valid_s1;
    logic                                  valid_s2;

    assign data_in_ready = data_out_ready;  // Whole chain stalls together

    // Data symbols first, parity at positions RS_K and up
    always_comb begin
        for (int i = 0; i < `FEC_NUM_CW; i++) begin
            for (int j = 0; j < `FEC_RS_K; j++)
                cw_in[i][j] = data_in[i*`FEC_RS_K + j];
            for (int k = 0; k < `FEC_RS_2T; k++)
                cw_in[i][`FEC_RS_K + k] = parity_in[i*`FEC_RS_2T + k];
        end
    end

    // Survivors get consecutive slots in position order
    always_comb begin
        pos_idx_t count;
        count = '0;
        for (int p = 0; p < `FEC_RS_N; p++) begin
            out_idx_c[p] = count;
            if (!erase_s1[p])
                count = count + 3'd1;
        end
    end

    // ########################################################################
    // Every pipeline stage moves only with data_out_ready
    // ########################################################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_s1       <= 1'b0;
            valid_s2       <= 1'b0;
            data_out_valid <= 1'b0;
        end else if (data_out_ready) begin
            valid_s1       <= data_in_valid;
            valid_s2       <= valid_s1;
            data_out_valid <= valid_s2;
        end
    end

    always_ff @(posedge clk) begin
        if (data_out_ready) begin
            cw_s1      <= cw_in;                        // Stage 1 captures and looks up
            erase_s1   <= RS_ERR_LOC_LUT[err_loc_in];
            err_loc_s1 <= err_loc_in;
            cw_s2      <= cw_s1;                        // Stage 2 computes slot indices
            erase_s2   <= erase_s1;
            out_idx_s2 <= out_idx_c;
            err_loc_s2 <= err_loc_s1;
            for (int i = 0; i < `FEC_NUM_CW; i++)       // Stage 3 compresses
                for (int p = 0; p < `FEC_RS_N; p++)
                    if (!erase_s2[p])
                        data_out[i*`FEC_RS_K + int'(out_idx_s2[p])] <= cw_s2[i][p];
            err_loc_out <= err_loc_s2;
        end
    end

    a_err_loc_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        (data_in_valid && data_in_ready) |-> (err_loc_in < `FEC_NUM_H)
    ) else $error("fec_err_inject: erasure index %0d out of range", err_loc_in);

endmodule

`default_nettype wire

//--- rtl/fec_pkg.sv
`include "fec_config.svh"
`default_nettype none

package fec_pkg;

    typedef logic [`FEC_SYM_SIZE-1:0] sym_t;
    typedef logic [3:0]               err_loc_t;
    typedef logic [2:0]               pos_idx_t;

    // ########################################################################
    // Bit p of an erasure pattern is set when position p is erased
    // Positions 0..3 are data, 4 is P0, 5 is P1
    // ########################################################################
    localparam logic [`FEC_RS_N-1:0] RS_ERR_LOC_LUT [`FEC_NUM_H] = '{
        6'b000011, 6'b000101, 6'b001001, 6'b010001, 6'b100001,  // (0,x)
        6'b000110, 6'b001010, 6'b010010, 6'b100010,             // (1,x)
        6'b001100, 6'b010100, 6'b100100,                        // (2,x)
        6'b011000, 6'b101000,                                   // (3,x)
        6'b110000                                               // Both parity
    };

    // GF(16) product over the field polynomial x^4+x+1
    function automatic sym_t gf_mul(sym_t a, sym_t b);
        sym_t prod;
        sym_t x;
        prod = '0;
        x    = a;
        for (int i = 0; i < `FEC_SYM_SIZE; i++) begin
            if (b[i])
                prod ^= x;
            x = {x[2:0], 1'b0} ^ (x[3] ? 4'h3 : 4'h0);  // Multiply by alpha
        end
        return prod;
    endfunction

    // Multiplicative inverse by table where zero maps to zero
    function automatic sym_t gf_inv(sym_t a);
        case (a)
            4'h1:    return 4'h1;
            4'h2:    return 4'h9;
            4'h3:    return 4'he;
            4'h4:    return 4'hd;
            4'h5:    return 4'hb;
            4'h6:    return 4'h7;
            4'h7:    return 4'h6;
            4'h8:    return 4'hf;
            4'h9:    return 4'h2;
            4'ha:    return 4'hc;
            4'hb:    return 4'h5;
            4'hc:    return 4'ha;
            4'hd:    return 4'h4;
            4'he:    return 4'h3;
            4'hf:    return 4'h8;
            default: return 4'h0;
        endcase
    endfunction

    // alpha^e for codeword positions only
    function automatic sym_t gf_alpha_pow(pos_idx_t e);
        case (e)
            3'd0:    return 4'h1;
            3'd1:    return 4'h2;
            3'd2:    return 4'h4;
            3'd3:    return 4'h8;
            3'd4:    return 4'h3;
            3'd5:    return 4'h6;
            3'd6:    return 4'hc;
            default: return 4'hb;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build the erasure path testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
    -f verilog.f \
    --top-module fec_erasure_path_tb \
    --Mdir "$BUILD_DIR" -o fec_sim
if [ $? -ne 0 ]; then
    echo "run_sim: Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/fec_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "run_sim: simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TEST PASSED" "$LOG"; then
    echo "run_sim: simulation passed"
    exit 0
fi
echo "run_sim: pass message not found in $LOG"
exit 1

//--- verilog.f
+incdir+rtl
rtl/fec_pkg.sv
rtl/fec_encoder.sv
rtl/fec_err_inject.sv
rtl/fec_erasure_decoder.sv
rtl/fec_erasure_path.sv
bench/fec_erasure_path_tb.sv
